// File: tests/mem_hier_stimulus.txt
# M line_addr line_data(word7..word0) | L test line_addr expected_line
# A/P test port(I/D) op(R/W) addr wdata mask expected_rdata pmem_transfers (P joins next A)
M 0100 1f171e161d151c141b131a1219111810
M 0040 70076006500540043003200210010abc
M 0240 c7c7c6c6c5c5c4c4c3c3c2c2c1c1c0c0
M 0200 27072606250524042303220221012000
M 0320 37373636353534343333323231313030
A 2 I R 0104 0000 0 1a12 1
A 2 I R 010e 0000 0 1f17 0
A 2 D R 0046 0000 0 3003 1
A 2 D R 0040 0000 0 0abc 0
A 2 D R 0088 0000 0 a54b 1
A 3 D W 0042 bbaa 1 0000 0
A 3 D R 0042 0000 0 10aa 0
A 3 D W 0044 ccdd 2 0000 0
A 3 D R 0044 0000 0 cc02 0
A 3 D W 0048 1234 3 0000 0
A 3 D R 0048 0000 0 1234 0
A 3 D W 0062 7755 2 0000 1
A 3 D R 0062 0000 0 77a1 0
A 4 D R 0244 0000 0 c2c2 2
L 4 0040 70076006500512343003cc0210aa0abc
A 4 D R 0042 0000 0 10aa 1
A 4 D R 0048 0000 0 1234 0
P 5 I R 0206 0000 0 2303 1
A 5 D R 032a 0000 0 3535 1
A 5 I R 0200 0000 0 2000 0
A 5 D R 0320 0000 0 3030 0

// File: mem_hier.f
verilog/lc3b_types.sv
verilog/i_cache.sv
verilog/d_cache.sv
verilog/arbiter.sv
verilog/mem_hier.sv
tests/mem_hier_sva.sv
tests/mem_hier_tb.sv

// File: Bender.yml
package:
  name: mem_hier

sources:
  - files:
      - verilog/lc3b_types.sv
      - verilog/i_cache.sv
      - verilog/d_cache.sv
      - verilog/arbiter.sv
      - verilog/mem_hier.sv
  - target: test
    files:
      - tests/mem_hier_sva.sv
      - tests/mem_hier_tb.sv

// File: tests/mem_hier_tb.sv
`timescale 1ns/1ns

module mem_hier_tb;

    import lc3b_types::*;

    localparam int TIMEOUT_CYCLES = 200;  // Longest wait for one resp.
    localparam int MAX_TOKENS     = 500;  // Bound on stimulus records.

    // One CPU-side access taken from the stimulus file.
    typedef struct packed {
        logic          is_d;
        logic          is_write;
        lc3b_word      addr;
        lc3b_word      wdata;
        lc3b_mem_wmask mask;
        lc3b_word      exp_data;
        logic [7:0]    exp_pmem;  // Physical transfers the access costs.
    } access_t;

    logic           clk;
    logic           i_arst_n;
    lc3b_mem_req_t  i_ireq;
    lc3b_mem_req_t  i_dreq;
    logic           i_pmem_resp;
    lc3b_pmem_data  i_pmem_rdata;
    logic           o_iresp;
    logic           o_dresp;
    lc3b_word       o_irdata;
    lc3b_word       o_drdata;
    lc3b_pmem_req_t o_pmem_req;

    lc3b_pmem_data  mem_lines [lc3b_word];  // Keyed by line number.
    lc3b_pmem_req_t mem_req;                // Request being served.
    logic           mem_busy;
    int             mem_wait;
    int             pmem_count;
    int             errors;
    int             test_errors;
    int             tests_run;
    int             cur_test;
    logic           stalled;                // A port never answered.

    mem_hier u_dut (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_ireq       (i_ireq),
        .i_dreq       (i_dreq),
        .i_pmem_resp  (i_pmem_resp),
        .i_pmem_rdata (i_pmem_rdata),
        .o_iresp      (o_iresp),
        .o_dresp      (o_dresp),
        .o_irdata     (o_irdata),
        .o_drdata     (o_drdata),
        .o_pmem_req   (o_pmem_req)
    );

    always #20 clk = ~clk;

    // Lines never loaded hold a pattern built from each word's byte address.
    function automatic lc3b_pmem_data model_line(lc3b_word addr);
        lc3b_pmem_data line;
        line = '0;
        if (mem_lines.exists(addr[15:4])) begin
            line = mem_lines[addr[15:4]];
        end else begin
            for (int w = 0; w < LINE_BYTES / 2; w++) begin
                line[w*16 +: 16] = {addr[15:4], 4'(w * 2)} ^ 16'ha5c3;
            end
        end
        return line;
    endfunction

    function automatic lc3b_mem_req_t to_req(access_t a);
        lc3b_mem_req_t req;
        req.read        = !a.is_write;
        req.write       = a.is_write;
        req.byte_enable = a.mask;
        req.address     = a.addr;
        req.wdata       = a.wdata;
        return req;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    task automatic check_word(string name, lc3b_word exp, lc3b_word act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_line(string name, lc3b_pmem_data exp, lc3b_pmem_data act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            if (test_errors == 0) begin
                $display("Test %0d: pass", cur_test);
            end else begin
                $display("Test %0d: %0d failed check(s)", cur_test, test_errors);
            end
            tests_run++;
        end
        test_errors = 0;
    endtask

    task automatic skip_line(int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Physical memory model that answers after 1 to 6 cycles.
    always begin
        @(posedge clk);
        #2;
        if (i_pmem_resp) begin
            i_pmem_resp = 1'b0;  // Resp lasts one cycle.
        end else if (mem_busy) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                if (mem_req.write) begin
                    mem_lines[mem_req.address[15:4]] = mem_req.wdata;
                end else begin
                    i_pmem_rdata = model_line(mem_req.address);
                end
                i_pmem_resp = 1'b1;
                mem_busy    = 1'b0;
                pmem_count++;
            end
        end else if (o_pmem_req.read || o_pmem_req.write) begin
            mem_req  = o_pmem_req;
            mem_busy = 1'b1;
            mem_wait = 1 + int'($urandom % 6);
        end
    end

    // Issues one access, or an instruction and a data access in the same cycle.
    task automatic run_accesses(access_t first, access_t second, logic paired);
        access_t  acc_i;
        access_t  acc_d;
        logic     has_i;
        logic     has_d;
        logic     i_wait;
        logic     d_wait;
        logic     i_drop;
        logic     d_drop;
        lc3b_word i_data;
        lc3b_word d_data;
        int       cycles;
        int       want_pmem;
        acc_i = '0;
        acc_d = '0;
        @(posedge clk);
        #2;
        pmem_count = 0;
        has_i      = !first.is_d || (paired && !second.is_d);
        has_d      = first.is_d || (paired && second.is_d);
        if (first.is_d) begin
            acc_d = first;
            acc_i = second;
        end else begin
            acc_i = first;
            acc_d = second;
        end
        want_pmem = paired ? first.exp_pmem + second.exp_pmem : first.exp_pmem;
        if (has_i) begin
            i_ireq = to_req(acc_i);
        end
        if (has_d) begin
            i_dreq = to_req(acc_d);
        end
        i_wait = has_i;
        d_wait = has_d;
        i_drop = 1'b0;
        d_drop = 1'b0;
        cycles = 0;
        while ((i_wait || d_wait) && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
            if (i_drop) begin
                i_ireq = '0;  // Held through the resp cycle.
                i_drop = 1'b0;
            end
            if (d_drop) begin
                i_dreq = '0;
                d_drop = 1'b0;
            end
            if (i_wait && o_iresp) begin
                i_data = o_irdata;
                i_wait = 1'b0;
                i_drop = 1'b1;
            end
            if (d_wait && o_dresp) begin
                d_data = o_drdata;
                d_wait = 1'b0;
                d_drop = 1'b1;
            end
        end
        if (i_wait || d_wait) begin
            if (i_wait) begin
                $display("Timeout: instruction port stalled at address %h", acc_i.addr);
            end
            if (d_wait) begin
                $display("Timeout: data port stalled at address %h", acc_d.addr);
            end
            errors++;
            test_errors++;
            stalled = 1'b1;
        end else begin
            @(posedge clk);
            #2;
            if (i_drop) begin
                i_ireq = '0;
            end
            if (d_drop) begin
                i_dreq = '0;
            end
            if (has_i && !acc_i.is_write) begin
                check_word("o_irdata", acc_i.exp_data, i_data);
            end
            if (has_d && !acc_d.is_write) begin
                check_word("o_drdata", acc_d.exp_data, d_data);
            end
            check_count("pmem transfers", want_pmem, pmem_count);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    initial begin
        int            fd;
        int            code;
        int            tokens;
        int            test;
        int            npmem;
        logic [7:0]    kind;
        logic [7:0]    port;
        logic [7:0]    op;
        lc3b_word      addr;
        lc3b_word      wdata;
        lc3b_word      exp_data;
        lc3b_mem_wmask mask;
        lc3b_pmem_data line;
        access_t       acc;
        access_t       held;
        logic          have_held;
        void'($urandom(32'hbce7));
        clk          = 1'b0;
        i_arst_n     = 1'b0;
        i_ireq       = '0;
        i_dreq       = '0;
        i_pmem_resp  = 1'b0;
        i_pmem_rdata = '0;
        mem_busy     = 1'b0;
        mem_wait     = 0;
        pmem_count   = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        stalled      = 1'b0;
        have_held    = 1'b0;
        held         = '0;
        cur_test     = 1;
        repeat (10) @(posedge clk);
        #2;
        check_bit("o_iresp", 1'b0, o_iresp);
        check_bit("o_dresp", 1'b0, o_dresp);
        check_bit("o_pmem_req.read", 1'b0, o_pmem_req.read);
        check_bit("o_pmem_req.write", 1'b0, o_pmem_req.write);
        i_arst_n = 1'b1;
        fd = $fopen("tests/mem_hier_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            tokens = 0;
            while (!$feof(fd) && tokens < MAX_TOKENS && !stalled) begin
                tokens++;
                code = $fscanf(fd, " %c", kind);
                if (code == 1) begin
                    case (kind)
                        "#": skip_line(fd);
                        "M": begin
                            code = $fscanf(fd, "%h %h", addr, line);
                            mem_lines[addr[15:4]] = line;
                        end
                        "L": begin
                            code = $fscanf(fd, "%d %h %h", test, addr, line);
                            if (test != cur_test) begin
                                close_test();
                                cur_test = test;
                            end
                            check_line("model line", line, model_line(addr));
                        end
                        "A", "P": begin
                            code = $fscanf(fd, "%d %c %c %h %h %h %h %d", test, port, op,
                                           addr, wdata, mask, exp_data, npmem);
                            if (test != cur_test) begin
                                close_test();
                                cur_test = test;
                            end
                            acc.is_d     = (port == "D");
                            acc.is_write = (op == "W");
                            acc.addr     = addr;
                            acc.wdata    = wdata;
                            acc.mask     = mask;
                            acc.exp_data = exp_data;
                            acc.exp_pmem = npmem[7:0];
                            if (kind == "P") begin
                                held      = acc;  // Goes out with the next access.
                                have_held = 1'b1;
                            end else if (have_held) begin
                                run_accesses(held, acc, 1'b1);
                                have_held = 1'b0;
                            end else begin
                                run_accesses(acc, acc, 1'b0);
                            end
                        end
                        default: begin
                            $display("Unknown record kind %c in the stimulus file", kind);
                            errors++;
                            skip_line(fd);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        close_test();
        $display("Tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : mem_hier_tb

// File: tests/mem_hier_sva.sv
`timescale 1ns/1ns

module mem_hier_sva (
    input logic                       clk,
    input logic                       i_arst_n,
    input lc3b_types::lc3b_mem_req_t  i_ireq,
    input lc3b_types::lc3b_mem_req_t  i_dreq,
    input logic                       i_iresp,
    input logic                       i_dresp,
    input logic                       i_pmem_resp,
    input lc3b_types::lc3b_pmem_req_t i_pmem_req
);

    // ~~~~~~~~~~~~~~~~~~~~
    // CPU side
    a_iresp_pending: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_iresp |-> (i_ireq.read || i_ireq.write))
        else $error("Instruction resp without a pending request.");

    a_dresp_pending: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_dresp |-> (i_dreq.read || i_dreq.write))
        else $error("Data resp without a pending request.");

    // ~~~~~~~~~~~~~~~~~~~~
    // Physical side
    a_pmem_onehot: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_pmem_req.read && i_pmem_req.write))
        else $error("Physical read and write both high.");

    a_pmem_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_pmem_req.read || i_pmem_req.write) && !i_pmem_resp |=> $stable(i_pmem_req))
        else $error("Physical request changed before resp.");

endmodule : mem_hier_sva

bind mem_hier mem_hier_sva u_sva (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_ireq      (i_ireq),
    .i_dreq      (i_dreq),
    .i_iresp     (o_iresp),
    .i_dresp     (o_dresp),
    .i_pmem_resp (i_pmem_resp),
    .i_pmem_req  (o_pmem_req)
);

// File: verilog/mem_hier.sv
`timescale 1ns/1ns

module mem_hier (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  lc3b_types::lc3b_mem_req_t  i_ireq,
    input  lc3b_types::lc3b_mem_req_t  i_dreq,
    input  logic                       i_pmem_resp,
    input  lc3b_types::lc3b_pmem_data  i_pmem_rdata,
    output logic                       o_iresp,
    output logic                       o_dresp,
    output lc3b_types::lc3b_word       o_irdata,
    output lc3b_types::lc3b_word       o_drdata,
    output lc3b_types::lc3b_pmem_req_t o_pmem_req
);

    import lc3b_types::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // Cache to arbiter wiring
    lc3b_pmem_req_t ic_pmem_req;   // Instruction cache line request.
    lc3b_pmem_req_t dc_pmem_req;   // Data cache line request.
    logic           ic_pmem_resp;
    logic           dc_pmem_resp;
    lc3b_pmem_data  arb_rdata;     // Shared fill data.

    i_cache u_i_cache (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_ireq),
        .i_pmem_resp  (ic_pmem_resp),
        .i_pmem_rdata (arb_rdata),
        .o_resp       (o_iresp),
        .o_rdata      (o_irdata),
        .o_pmem_req   (ic_pmem_req)
    );

    d_cache u_d_cache (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_dreq),
        .i_pmem_resp  (dc_pmem_resp),
        .i_pmem_rdata (arb_rdata),
        .o_resp       (o_dresp),
        .o_rdata      (o_drdata),
        .o_pmem_req   (dc_pmem_req)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Single physical port
    arbiter u_arbiter (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_i_pmem_req  (ic_pmem_req),
        .i_d_pmem_req  (dc_pmem_req),
        .i_pmem_resp   (i_pmem_resp),
        .i_pmem_rdata  (i_pmem_rdata),
        .o_i_pmem_resp (ic_pmem_resp),
        .o_d_pmem_resp (dc_pmem_resp),
        .o_pmem_rdata  (arb_rdata),
        .o_pmem_req    (o_pmem_req)
    );

endmodule : mem_hier

// File: verilog/arbiter.sv
`timescale 1ns/1ns

module arbiter (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  lc3b_types::lc3b_pmem_req_t i_i_pmem_req,
    input  lc3b_types::lc3b_pmem_req_t i_d_pmem_req,
    input  logic                       i_pmem_resp,
    input  lc3b_types::lc3b_pmem_data  i_pmem_rdata,
    output logic                       o_i_pmem_resp,
    output logic                       o_d_pmem_resp,
    output lc3b_types::lc3b_pmem_data  o_pmem_rdata,
    output lc3b_types::lc3b_pmem_req_t o_pmem_req
);

    import lc3b_types::*;

    arb_state_e state_q;
    arb_state_e state_d;
    logic       i_pending;
    logic       d_pending;

    assign i_pending = i_i_pmem_req.read || i_i_pmem_req.write;
    assign d_pending = i_d_pmem_req.read || i_d_pmem_req.write;

    // ~~~~~~~~~~~~~~~~~~~~
    // Grant FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (d_pending) begin
                    state_d = ARB_D;  // Data side wins ties.
                end else if (i_pending) begin
                    state_d = ARB_I;
                end
            end
            ARB_I, ARB_D: begin
                if (i_pmem_resp) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Steering
    always_comb begin
        o_pmem_req    = '0;  // Nothing forwarded without an owner.
        o_i_pmem_resp = 1'b0;
        o_d_pmem_resp = 1'b0;
        case (state_q)
            ARB_I: begin
                o_pmem_req    = i_i_pmem_req;
                o_i_pmem_resp = i_pmem_resp;
            end
            ARB_D: begin
                o_pmem_req    = i_d_pmem_req;
                o_d_pmem_resp = i_pmem_resp;
            end
            default: begin
                o_pmem_req = '0;
            end
        endcase
    end

    // Both clients see the line but only the owner sees resp.
    assign o_pmem_rdata = i_pmem_rdata;

endmodule : arbiter

// File: verilog/d_cache.sv
`timescale 1ns/1ns

module d_cache (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  lc3b_types::lc3b_mem_req_t  i_req,
    input  logic                       i_pmem_resp,
    input  lc3b_types::lc3b_pmem_data  i_pmem_rdata,
    output logic                       o_resp,
    output lc3b_types::lc3b_word       o_rdata,
    output lc3b_types::lc3b_pmem_req_t o_pmem_req
);

    import lc3b_types::*;

    cache_state_e        state_q;
    lc3b_pmem_data       line_q [NUM_SETS];  // Line storage.
    lc3b_tag             tag_q  [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;            // Line differs from memory.

    lc3b_tag       req_tag;
    lc3b_index     req_idx;
    lc3b_offset    req_off;
    logic          req_valid;
    logic          hit;
    logic          victim_dirty;
    lc3b_word      cur_word;
    lc3b_word      merged_word;
    lc3b_pmem_data merged_line;

    assign {req_tag, req_idx, req_off} = i_req.address;
    assign req_valid    = i_req.read || i_req.write;
    assign hit          = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign victim_dirty = valid_q[req_idx] && dirty_q[req_idx];

    // ~~~~~~~~~~~~~~~~~~~~
    // Word select and byte merge
    always_comb begin
        cur_word    = line_q[req_idx][req_off[3:1]*$bits(lc3b_word) +: $bits(lc3b_word)];
        merged_word = cur_word;
        if (i_req.byte_enable[0]) begin
            merged_word[7:0] = i_req.wdata[7:0];    // Low byte.
        end
        if (i_req.byte_enable[1]) begin
            merged_word[15:8] = i_req.wdata[15:8];  // High byte.
        end
        merged_line = line_q[req_idx];
        merged_line[req_off[3:1]*$bits(lc3b_word) +: $bits(lc3b_word)] = merged_word;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Physical side
    always_comb begin
        o_pmem_req       = '0;
        o_pmem_req.wdata = line_q[req_idx];  // Victim line.
        case (state_q)
            WRITEBACK: begin
                o_pmem_req.write   = 1'b1;
                // Old line goes back to where its stored tag says.
                o_pmem_req.address = {tag_q[req_idx], req_idx,
                                      {$clog2(LINE_BYTES){1'b0}}};
            end
            FILL: begin
                o_pmem_req.read    = 1'b1;
                o_pmem_req.address = {req_tag, req_idx, {$clog2(LINE_BYTES){1'b0}}};
            end
            default: begin
                o_pmem_req.read = 1'b0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Controller
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
            valid_q <= '0;
            dirty_q <= '0;
            o_resp  <= 1'b0;
        end else begin
            o_resp <= 1'b0;  // Single cycle pulse.
            case (state_q)
                IDLE: begin
                    if (req_valid && !o_resp) begin
                        if (hit) begin
                            state_q <= RESPOND;
                        end else if (victim_dirty) begin
                            state_q <= WRITEBACK;
                        end else begin
                            state_q <= FILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (i_pmem_resp) begin
                        state_q <= FILL;  // Now fetch the new line.
                    end
                end
                FILL: begin
                    if (i_pmem_resp) begin
                        valid_q[req_idx] <= 1'b1;
                        dirty_q[req_idx] <= 1'b0;
                        state_q          <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (i_req.write) begin
                        dirty_q[req_idx] <= 1'b1;
                    end
                    o_resp  <= 1'b1;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Line, tag and read data.
    always_ff @(posedge clk) begin
        if (state_q == FILL && i_pmem_resp) begin
            line_q[req_idx] <= i_pmem_rdata;
            tag_q[req_idx]  <= req_tag;
        end else if (state_q == RESPOND && i_req.write) begin
            line_q[req_idx] <= merged_line;  // Write lands before resp.
        end
        if (state_q == RESPOND) begin
            o_rdata <= cur_word;
        end
    end

endmodule : d_cache

// File: verilog/i_cache.sv
`timescale 1ns/1ns

module i_cache (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  lc3b_types::lc3b_mem_req_t  i_req,
    input  logic                       i_pmem_resp,
    input  lc3b_types::lc3b_pmem_data  i_pmem_rdata,
    output logic                       o_resp,
    output lc3b_types::lc3b_word       o_rdata,
    output lc3b_types::lc3b_pmem_req_t o_pmem_req
);

    import lc3b_types::*;

    cache_state_e        state_q;
    lc3b_pmem_data       line_q [NUM_SETS];  // Line storage.
    lc3b_tag             tag_q  [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    lc3b_tag    req_tag;
    lc3b_index  req_idx;
    lc3b_offset req_off;
    logic       hit;
    lc3b_word   cur_word;

    assign {req_tag, req_idx, req_off} = i_req.address;
    assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    // Word picked out of the indexed line.
    assign cur_word = line_q[req_idx][req_off[3:1]*$bits(lc3b_word) +: $bits(lc3b_word)];

    // ~~~~~~~~~~~~~~~~~~~~
    // Physical side
    always_comb begin
        o_pmem_req = '0;  // Read only, never writes.
        if (state_q == FILL) begin
            o_pmem_req.read    = 1'b1;
            o_pmem_req.address = {req_tag, req_idx, {$clog2(LINE_BYTES){1'b0}}};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Controller
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
            valid_q <= '0;
            o_resp  <= 1'b0;
        end else begin
            o_resp <= 1'b0;  // Single cycle pulse.
            case (state_q)
                IDLE: begin
                    // Skip the resp cycle while the old request is still held.
                    if (i_req.read && !o_resp) begin
                        state_q <= hit ? RESPOND : FILL;
                    end
                end
                FILL: begin
                    if (i_pmem_resp) begin
                        valid_q[req_idx] <= 1'b1;
                        state_q          <= RESPOND;
                    end
                end
                RESPOND: begin
                    o_resp  <= 1'b1;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Line, tag and read data.
    always_ff @(posedge clk) begin
        if (state_q == FILL && i_pmem_resp) begin
            line_q[req_idx] <= i_pmem_rdata;
            tag_q[req_idx]  <= req_tag;
        end
        if (state_q == RESPOND) begin
            o_rdata <= cur_word;
        end
    end

endmodule : i_cache

// File: verilog/lc3b_types.sv
package lc3b_types;

    // ~~~~~~~~~~~~~~~~~~~~
    // Geometry
    localparam int NUM_SETS   = 8;   // Sets per cache.
    localparam int LINE_BYTES = 16;  // Bytes per cache line.

    // ~~~~~~~~~~~~~~~~~~~~
    // Basic widths
    typedef logic [15:0]               lc3b_word;       // Address or data word.
    typedef logic [1:0]                lc3b_mem_wmask;  // One enable per byte.
    typedef logic [LINE_BYTES*8-1:0]   lc3b_pmem_data;  // Whole cache line.

    // Word address split as tag | index | offset.
    typedef logic [3:0] lc3b_offset;  // Word select in [3:1], byte select in [0].
    typedef logic [2:0] lc3b_index;   // Set number.
    typedef logic [8:0] lc3b_tag;     // Upper address bits.

    // ~~~~~~~~~~~~~~~~~~~~
    // Request bundles
    typedef struct packed {
        logic          read;         // Read level.
        logic          write;        // Write level.
        lc3b_mem_wmask byte_enable;  // Bytes to write.
        lc3b_word      address;      // Byte address.
        lc3b_word      wdata;        // Write data.
    } lc3b_mem_req_t;

    typedef struct packed {
        logic          read;     // Line read level.
        logic          write;    // Line write level.
        lc3b_word      address;  // Line address with zero offset.
        lc3b_pmem_data wdata;    // Line to write.
    } lc3b_pmem_req_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Controller states
    typedef enum logic [1:0] {
        IDLE,       // Waiting for a request.
        WRITEBACK,  // Dirty victim going out.
        FILL,       // Line coming in.
        RESPOND     // Answer the requester.
    } cache_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,  // No owner.
        ARB_I,     // Instruction cache owns memory.
        ARB_D      // Data cache owns memory.
    } arb_state_e;

endpackage : lc3b_types
